// ==== run.sh ====
#!/bin/sh
# Build and run the game testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module game_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vgame_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1

// ==== source/frame_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_timer #(
    parameter int TICK_CYCLES = 833333
) (
    input  wire logic CLOCK_50,
    input  wire logic rst_n,
    output logic      tick
);

    localparam int cnt_w = $clog2(TICK_CYCLES + 1);

    logic [cnt_w-1:0] cnt;

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == cnt_w'(TICK_CYCLES - 1)) begin
            cnt  <= '0;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/game_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module game_fsm import game_pkg::*; (
    input  wire logic CLOCK_50,
    input  wire logic rst_n,
    input  wire dir_e held_dir,
    input  wire logic tick,
    output logic      cmd_valid,
    output rect_cmd_t cmd,
    input  wire logic cmd_ready
);

    fsm_state_e state;
    x_t         pos_x;
    y_t         pos_y;
    x_t         nxt_x;
    y_t         nxt_y;
    x_t         step_x;
    y_t         step_y;
    logic       cmd_fire;

    assign cmd_fire = cmd_valid && cmd_ready;

    // One square step in the held direction, wrapping at the canvas edges
    always_comb begin
        step_x = pos_x;
        step_y = pos_y;
        case (held_dir)
            dir_up: begin
                step_y = (pos_y == '0) ? y_t'(canvas_h - sq_size)
                                       : pos_y - y_t'(sq_size);
            end
            dir_down: begin
                step_y = (pos_y == y_t'(canvas_h - sq_size)) ? '0
                                                             : pos_y + y_t'(sq_size);
            end
            dir_left: begin
                step_x = (pos_x == '0) ? x_t'(canvas_w - sq_size)
                                       : pos_x - x_t'(sq_size);
            end
            dir_right: begin
                step_x = (pos_x == x_t'(canvas_w - sq_size)) ? '0
                                                             : pos_x + x_t'(sq_size);
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_init;
            pos_x <= x_t'(start_x);
            pos_y <= y_t'(start_y);
        end else begin
            case (state)
                st_init: if (cmd_fire) state <= st_idle;
                st_idle: if (tick && held_dir != dir_none) state <= st_erase;
                st_erase: begin
                    // Old square is gone once the erase is taken
                    if (cmd_fire) begin
                        state <= st_draw;
                        pos_x <= nxt_x;
                        pos_y <= nxt_y;
                    end
                end
                st_draw: if (cmd_fire) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (state == st_idle && tick) begin
            nxt_x <= step_x;
            nxt_y <= step_y;
        end
    end

    // Command fields only move on a transfer, so they hold while stalled
    always_comb begin
        cmd_valid = (state != st_idle);
        cmd.kind  = (state == st_erase) ? cmd_erase : cmd_draw;
        cmd.x     = pos_x;
        cmd.y     = pos_y;
    end

endmodule

`default_nettype wire

// ==== source/game_pkg.sv ====
`default_nettype none

package game_pkg;

    // Canvas geometry in pixels
    localparam int canvas_w = 160;
    localparam int canvas_h = 120;

    // Square edge, also the move step
    localparam int sq_size = 4;

    // Square position after reset
    localparam int start_x = 76;
    localparam int start_y = 56;

    typedef logic [7:0] x_t;
    typedef logic [6:0] y_t;

    // 4 bits per channel, red in the top nibble
    typedef logic [11:0] color_t;

    localparam color_t bg_color     = 12'h000;
    localparam color_t player_color = 12'hf00;

    typedef logic [7:0] scan_t;

    // Set 2 scan codes for the movement keys
    localparam scan_t sc_w     = 8'h1d;
    localparam scan_t sc_a     = 8'h1c;
    localparam scan_t sc_s     = 8'h1b;
    localparam scan_t sc_d     = 8'h23;
    localparam scan_t sc_break = 8'hf0;

    typedef enum logic [2:0] {
        dir_none,
        dir_up,
        dir_down,
        dir_left,
        dir_right
    } dir_e;

    typedef enum logic {
        cmd_erase,
        cmd_draw
    } cmd_kind_e;

    // x and y give the top-left corner of the square
    typedef struct packed {
        cmd_kind_e kind;
        x_t        x;
        y_t        y;
    } rect_cmd_t;

    typedef struct packed {
        x_t     x;
        y_t     y;
        color_t color;
    } pixel_t;

    typedef enum logic [1:0] {
        st_init,
        st_idle,
        st_erase,
        st_draw
    } fsm_state_e;

    typedef enum logic {
        plot_idle,
        plot_busy
    } plot_state_e;

endpackage

`default_nettype wire

// ==== source/game_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module game_top import game_pkg::*; #(
    parameter int TICK_CYCLES     = 833333,
    parameter int PS2_SYNC_STAGES = 2
) (
    input  wire logic CLOCK_50,
    input  wire logic rst_n,
    input  wire logic PS2_CLK,
    input  wire logic PS2_DAT,
    output logic      pix_valid,
    output pixel_t    pix,
    input  wire logic pix_ready
);

    logic      key_valid;
    scan_t     key_code;
    dir_e      held_dir;
    logic      tick;
    logic      cmd_valid;
    rect_cmd_t cmd;
    logic      cmd_ready;

    // Keyboard path
    ps2_receiver #(
        .PS2_SYNC_STAGES(PS2_SYNC_STAGES)
    ) rx_i (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .PS2_CLK  (PS2_CLK),
        .PS2_DAT  (PS2_DAT),
        .key_valid(key_valid),
        .key_code (key_code)
    );

    key_tracker tracker_i (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .key_valid(key_valid),
        .key_code (key_code),
        .held_dir (held_dir)
    );

    frame_timer #(
        .TICK_CYCLES(TICK_CYCLES)
    ) timer_i (
        .CLOCK_50(CLOCK_50),
        .rst_n   (rst_n),
        .tick    (tick)
    );

    game_fsm fsm_i (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .held_dir (held_dir),
        .tick     (tick),
        .cmd_valid(cmd_valid),
        .cmd      (cmd),
        .cmd_ready(cmd_ready)
    );

    // Pixel stream goes straight out to the sink
    rect_plotter plotter_i (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .cmd_valid(cmd_valid),
        .cmd      (cmd),
        .cmd_ready(cmd_ready),
        .pix_valid(pix_valid),
        .pix      (pix),
        .pix_ready(pix_ready)
    );

endmodule

`default_nettype wire

// ==== source/key_tracker.sv ====
`timescale 1ns/10ps
`default_nettype none

module key_tracker import game_pkg::*; (
    input  wire logic  CLOCK_50,
    input  wire logic  rst_n,
    input  wire logic  key_valid,
    input  wire scan_t key_code,
    output dir_e       held_dir
);

    logic break_pending;
    dir_e code_dir;

    function automatic dir_e code_to_dir(scan_t code);
        dir_e d;
        case (code)
            sc_w:    d = dir_up;
            sc_s:    d = dir_down;
            sc_a:    d = dir_left;
            sc_d:    d = dir_right;
            default: d = dir_none;
        endcase
        return d;
    endfunction

    assign code_dir = code_to_dir(key_code);

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            break_pending <= 1'b0;
            held_dir      <= dir_none;
        end else if (key_valid) begin
            if (key_code == sc_break) begin
                break_pending <= 1'b1;
            end else if (break_pending) begin
                break_pending <= 1'b0;
                // Release of some other key leaves the held one alone
                if (code_dir != dir_none && code_dir == held_dir) begin
                    held_dir <= dir_none;
                end
            end else if (code_dir != dir_none) begin
                // Typematic repeats land here with the same direction
                held_dir <= code_dir;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/ps2_receiver.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_receiver import game_pkg::*; #(
    parameter int PS2_SYNC_STAGES = 2
) (
    input  wire logic CLOCK_50,
    input  wire logic rst_n,
    input  wire logic PS2_CLK,
    input  wire logic PS2_DAT,
    output logic      key_valid,
    output scan_t     key_code
);

    // Top bit of the clock pipe is the previous synchronised value
    logic [PS2_SYNC_STAGES:0]   clk_pipe;
    logic [PS2_SYNC_STAGES-1:0] dat_pipe;
    logic                       clk_fall;
    logic [10:0]                frame;
    logic [3:0]                 bit_cnt;
    logic                       frame_done;
    logic                       frame_ok;

    assign clk_fall = clk_pipe[PS2_SYNC_STAGES] && !clk_pipe[PS2_SYNC_STAGES-1];

    // Start low, stop high, odd parity over data and parity bit
    assign frame_ok = !frame[0] && frame[10] && (^frame[9:1]);

    // Both lines idle high
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            clk_pipe <= '1;
            dat_pipe <= '1;
        end else begin
            clk_pipe <= {clk_pipe[PS2_SYNC_STAGES-1:0], PS2_CLK};
            dat_pipe <= {dat_pipe[PS2_SYNC_STAGES-2:0], PS2_DAT};
        end
    end

    // Bits arrive LSB first, so shift in from the top
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall) begin
            frame <= {dat_pipe[PS2_SYNC_STAGES-1], frame[10:1]};
        end
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt    <= '0;
            frame_done <= 1'b0;
            key_valid  <= 1'b0;
        end else begin
            frame_done <= clk_fall && (bit_cnt == 4'd10);
            key_valid  <= frame_done && frame_ok;
            if (clk_fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt <= '0;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // Code is held next to the strobe
    always_ff @(posedge CLOCK_50) begin
        if (frame_done) begin
            key_code <= frame[8:1];
        end
    end

endmodule

`default_nettype wire

// ==== source/rect_plotter.sv ====
`timescale 1ns/10ps
`default_nettype none

module rect_plotter import game_pkg::*; (
    input  wire logic      CLOCK_50,
    input  wire logic      rst_n,
    input  wire logic      cmd_valid,
    input  wire rect_cmd_t cmd,
    output logic           cmd_ready,
    output logic           pix_valid,
    output pixel_t         pix,
    input  wire logic      pix_ready
);

    localparam logic [1:0] last_off = 2'(sq_size - 1);

    plot_state_e state;
    cmd_kind_e   kind;
    x_t          base_x;
    y_t          base_y;
    logic [1:0]  col;
    logic [1:0]  row;
    logic        beat;

    assign cmd_ready = (state == plot_idle);
    assign pix_valid = (state == plot_busy);
    assign beat      = pix_valid && pix_ready;

    always_comb begin
        pix.x     = base_x + x_t'(col);
        pix.y     = base_y + y_t'(row);
        pix.color = (kind == cmd_draw) ? player_color : bg_color;
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            state <= plot_idle;
            col   <= '0;
            row   <= '0;
        end else if (state == plot_idle) begin
            if (cmd_valid) begin
                state <= plot_busy;
                col   <= '0;
                row   <= '0;
            end
        end else if (beat) begin
            // Row-major walk, column offset moves first
            col <= col + 2'd1;
            if (col == last_off) begin
                row <= row + 2'd1;
                if (row == last_off) begin
                    state <= plot_idle;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (cmd_valid && cmd_ready) begin
            kind   <= cmd.kind;
            base_x <= cmd.x;
            base_y <= cmd.y;
        end
    end

endmodule

`default_nettype wire

// ==== verif/game_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module game_tb import game_pkg::*; ();

    localparam int tick_cycles = 400;
    localparam int ps2_half    = 20;
    // Whole sequence spans about 80 ticks of 400 clocks
    localparam int max_cycles  = 60000;

    logic        CLOCK_50  = 1'b0;
    logic        rst_n     = 1'b1;
    logic        PS2_CLK   = 1'b1;
    logic        PS2_DAT   = 1'b1;
    logic        pix_ready = 1'b0;
    logic        pix_valid;
    pixel_t      pix;

    pixel_t      expected[$];
    pixel_t      exp_pix;
    dir_e        model_dir       = dir_none;
    int          model_x         = start_x;
    int          model_y         = start_y;
    bit          wrap_x_seen     = 1'b0;
    bit          wrap_y_seen     = 1'b0;
    int          run_cyc         = 0;
    int          cycle_count     = 0;
    int          beats           = 0;
    int          value_errors    = 0;
    int          protocol_errors = 0;
    int          other_errors    = 0;
    string       test_name       = "reset_draw";
    event        model_tick;

    game_top #(
        .TICK_CYCLES(tick_cycles)
    ) dut_i (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .PS2_CLK  (PS2_CLK),
        .PS2_DAT  (PS2_DAT),
        .pix_valid(pix_valid),
        .pix      (pix),
        .pix_ready(pix_ready)
    );

    initial begin
        forever #2 CLOCK_50 = ~CLOCK_50;
    end

    // Row-major walk over one square
    task automatic queue_square(input int bx, input int by, input color_t c);
        pixel_t p;
        for (int r = 0; r < sq_size; r++) begin
            for (int k = 0; k < sq_size; k++) begin
                p.x     = x_t'(bx + k);
                p.y     = y_t'(by + r);
                p.color = c;
                expected.push_back(p);
            end
        end
    endtask

    // Stepping off an edge lands on the far side of the canvas
    task automatic step_square(input dir_e d);
        case (d)
            dir_left: begin
                wrap_x_seen = wrap_x_seen || (model_x == 0);
                model_x = (model_x + canvas_w - sq_size) % canvas_w;
            end
            dir_right: model_x = (model_x + sq_size) % canvas_w;
            dir_up: begin
                wrap_y_seen = wrap_y_seen || (model_y == 0);
                model_y = (model_y + canvas_h - sq_size) % canvas_h;
            end
            dir_down: model_y = (model_y + sq_size) % canvas_h;
            default: ;
        endcase
    endtask

    // Frames start just after a tick so the key change lands mid period
    task automatic send_key(input scan_t code, input dir_e dir_after, input bit bad_parity);
        logic [10:0] bits;
        // Parity bit is flipped for a bad frame
        bits = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
        @(model_tick);
        for (int i = 0; i < 11; i++) begin
            PS2_DAT <= bits[i];
            repeat (ps2_half) @(posedge CLOCK_50);
            PS2_CLK <= 1'b0;
            repeat (ps2_half) @(posedge CLOCK_50);
            PS2_CLK <= 1'b1;
        end
        model_dir = dir_after;
    endtask

    task automatic wait_ticks(input int n);
        repeat (n) @(model_tick);
    endtask

    task automatic wait_drain();
        while (expected.size() != 0) begin
            @(posedge CLOCK_50);
        end
    endtask

    task automatic print_summary();
        $display("Summary: %0d pixels, %0d value errors, %0d protocol errors, %0d other errors",
                 beats, value_errors, protocol_errors, other_errors);
    endtask

    // Sink with back-pressure, pixel checker and tick model
    always @(posedge CLOCK_50) begin
        pix_ready <= ($urandom % 4) != 0;
        if (rst_n) begin
            run_cyc = run_cyc + 1;
            if (pix_valid && pix_ready) begin
                if (expected.size() == 0) begin
                    $display("Unexpected pixel at x=%0d y=%0d in %s", pix.x, pix.y, test_name);
                    other_errors++;
                end else begin
                    exp_pix = expected.pop_front();
                    beats++;
                    assert (pix == exp_pix) else begin
                        $display("FAILED %s: expected %0d,%0d %h, actual %0d,%0d %h",
                                 test_name, exp_pix.x, exp_pix.y, exp_pix.color,
                                 pix.x, pix.y, pix.color);
                        value_errors++;
                    end
                end
            end
            // Timer runs from reset release and a tick only counts with the stream idle
            if (run_cyc % tick_cycles == 0) begin
                if (model_dir != dir_none && expected.size() == 0) begin
                    queue_square(model_x, model_y, bg_color);
                    step_square(model_dir);
                    queue_square(model_x, model_y, player_color);
                end
                -> model_tick;
            end
        end
    end

    always @(posedge CLOCK_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == max_cycles) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", max_cycles);
            print_summary();
            $display("STATUS: FAIL");
            $finish;
        end
    end

    assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix))
    else begin
        $display("Pixel changed or was withdrawn while pix_ready was low");
        protocol_errors++;
    end

    assert property (@(posedge CLOCK_50)
        !rst_n |-> !pix_valid && dut_i.held_dir == dir_none)
    else begin
        $display("Pixel stream or held key not idle during reset");
        protocol_errors++;
    end

    initial begin
        void'($urandom(32'hd656_f2eb));
        rst_n <= 1'b0;
        queue_square(start_x, start_y, player_color);
        repeat (5) @(posedge CLOCK_50);
        rst_n <= 1'b1;
        wait_drain();

        test_name = "hold_right";
        send_key(sc_d, dir_right, 1'b0);
        wait_ticks(3);
        // Typematic repeat of the held key
        send_key(sc_d, dir_right, 1'b0);
        wait_ticks(2);
        test_name = "release_right";
        send_key(sc_break, dir_right, 1'b0);
        send_key(sc_d, dir_none, 1'b0);
        wait_ticks(3);

        test_name = "wrap_left";
        send_key(sc_a, dir_left, 1'b0);
        while (!wrap_x_seen) begin
            @(model_tick);
        end
        send_key(sc_break, dir_left, 1'b0);
        send_key(sc_a, dir_none, 1'b0);

        test_name = "wrap_up";
        send_key(sc_w, dir_up, 1'b0);
        while (!wrap_y_seen) begin
            @(model_tick);
        end
        send_key(sc_break, dir_up, 1'b0);
        send_key(sc_w, dir_none, 1'b0);

        test_name = "bad_parity";
        send_key(sc_s, dir_none, 1'b1);
        wait_ticks(2);
        wait_drain();
        repeat (20) @(posedge CLOCK_50);

        print_summary();
        if (value_errors + protocol_errors + other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/game_pkg.sv
source/ps2_receiver.sv
source/key_tracker.sv
source/frame_timer.sv
source/game_fsm.sv
source/rect_plotter.sv
source/game_top.sv
verif/game_tb.sv
